//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= sprite_walk_tb
FILELIST  ?= sprite_walk.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/display_timings.sv
// ==================================================
// reduced raster: 64x40 active, 80x46 total, sync active high
// frame and line strobes are decoded from the counters
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module display_timings import sprite_pkg::*; (
    input  logic                    clk_pix,
    input  logic                    rst,
    output logic signed [CORDW-1:0] sx,
    output logic signed [CORDW-1:0] sy,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output logic                    frame,
    output logic                    line
);

    // scan position
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= H_STA;
            sy <= V_STA;
        end else if (sx == H_END) begin
            sx <= H_STA;
            sy <= (sy == V_END) ? V_STA : sy + 16'sd1;
        end else begin
            sx <= sx + 16'sd1;
        end
    end

    always_comb begin
        hsync = (sx >= HS_STA) && (sx <= HS_END);
        vsync = (sy >= VS_STA) && (sy <= VS_END);
        de    = (sx >= 16'sd0) && (sy >= 16'sd0);  // blanking is negative
        frame = (sx == H_STA) && (sy == V_STA);
        line  = (sx == H_STA);
    end

endmodule

`default_nettype wire

//--- logic/pixel_compositor.sv
// ==================================================
// band index uses sy[5:3], so V_RES must stay within 64 lines
// outputs lag the scan counters by one cycle
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor import sprite_pkg::*; (
    input  logic                    clk_pix,
    input  logic                    rst,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    de,
    input  logic                    drawing,
    input  logic signed [CORDW-1:0] sy,
    input  logic [COLR_BITS-1:0]    pix,
    output logic [3:0]              red,
    output logic [3:0]              green,
    output logic [3:0]              blue,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    de_o
);

    logic [11:0] bg_colr;
    logic [11:0] colr;
    logic        spr_opaque;

    always_comb begin
        bg_colr    = '0;
        spr_opaque = drawing && (pix != SPR_TRANS);
        if (de) begin
            bg_colr = BG_BANDS[sy[5:3]];  // 8-line gradient bands
        end
        colr = spr_opaque ? PALETTE[pix] : bg_colr;
        if (!de) begin
            colr = '0;  // sprite may sit in blanking
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            {red, green, blue} <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            {red, green, blue} <= colr;
            hsync_o <= hsync;
            vsync_o <= vsync;
            de_o    <= de;
        end
    end

endmodule

`default_nettype wire

//--- logic/sprite_animator.sv
// ==================================================
// position and animation change only on the frame strobe
// start fires at sx = H_STA of the sprite's top line
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module sprite_animator import sprite_pkg::*; (
    input  logic                    clk_pix,
    input  logic                    rst,
    input  logic                    frame,
    input  logic                    line,
    input  logic signed [CORDW-1:0] sy,
    output logic signed [CORDW-1:0] sprx,
    output logic [SPR_ADDRW-1:0]    spr_base,
    output logic                    start
);

    logic [$clog2(ANIM_STEP)-1:0] cnt_frame;  // frames within a step
    logic [$clog2(ANIM_LEN)-1:0]  seq_idx;

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sprx      <= '0;
            cnt_frame <= '0;
            seq_idx   <= '0;
        end else if (frame) begin
            // walk left, reappear at the right edge once off screen
            sprx <= (sprx > SPR_X_MIN) ? sprx - SPR_SPEED_X : H_RES;

            if (cnt_frame == ANIM_STEP - 1) begin
                cnt_frame <= '0;
                seq_idx   <= (seq_idx == ANIM_LEN - 1) ? '0 : seq_idx + 1'b1;
            end else begin
                cnt_frame <= cnt_frame + 1'b1;
            end
        end
    end

    always_comb begin
        spr_base = SPR_ADDRW'(ANIM_SEQ[seq_idx] * SPR_PIXELS);  // frame offset in ROM
        start    = line && (sy == SPR_Y);
    end

endmodule

`default_nettype wire

//--- logic/sprite_engine.sv
// ==================================================
// sprx must stay >= -12 so the pre-fetch lands in blanking
// drawing is cut at the end of the line, never wraps over
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module sprite_engine import sprite_pkg::*; (
    input  logic                    clk_pix,
    input  logic                    rst,
    input  logic                    start,
    input  logic signed [CORDW-1:0] sx,
    input  logic signed [CORDW-1:0] sprx,
    input  logic [COLR_BITS-1:0]    data,
    output logic [SPR_ADDRW-1:0]    pos,
    output logic [COLR_BITS-1:0]    pix,
    output logic                    drawing
);

    logic [1:0] state;
    logic [1:0] state_next;
    logic [$clog2(SPR_WIDTH)-1:0]   cnt_x;      // texel column
    logic [$clog2(SPR_WIDTH)-1:0]   col_next;   // column needed next cycle
    logic [$clog2(SPR_SCALE_X)-1:0] sub_x;
    logic [$clog2(SPR_HEIGHT)-1:0]  cnt_y;      // texel line
    logic [$clog2(SPR_SCALE_Y)-1:0] sub_y;
    logic line_end;
    logic last_line;
    logic texel_end;
    logic row_done;

    always_comb begin
        line_end  = (sx == H_END);
        last_line = (cnt_y == SPR_HEIGHT - 1) && (sub_y == SPR_SCALE_Y - 1);
        texel_end = (sub_x == SPR_SCALE_X - 1);
        row_done  = texel_end && (cnt_x == SPR_WIDTH - 1);
    end

    // next state
    always_comb begin
        state_next = state;
        if (state != ENG_IDLE && line_end) begin
            state_next = last_line ? ENG_IDLE : ENG_AWAIT;  // next scan line
        end else begin
            case (state)
                ENG_IDLE:  if (start) state_next = ENG_AWAIT;
                ENG_AWAIT: if (sx == sprx - 16'sd1) state_next = ENG_DRAW;
                ENG_DRAW:  if (row_done) state_next = ENG_NEXT;
                default:   state_next = state;  // hold until line end
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= ENG_IDLE;
            cnt_x <= '0;
            sub_x <= '0;
            cnt_y <= '0;
            sub_y <= '0;
        end else begin
            state <= state_next;

            // horizontal scaling
            if (state_next != ENG_DRAW) begin
                cnt_x <= '0;
                sub_x <= '0;
            end else if (state == ENG_DRAW) begin
                if (texel_end) begin
                    sub_x <= '0;
                    cnt_x <= cnt_x + 1'b1;
                end else begin
                    sub_x <= sub_x + 1'b1;
                end
            end

            // vertical scaling, one step per scan line
            if (state == ENG_IDLE) begin
                cnt_y <= '0;
                sub_y <= '0;
            end else if (line_end) begin
                if (sub_y == SPR_SCALE_Y - 1) begin
                    sub_y <= '0;
                    cnt_y <= cnt_y + 1'b1;
                end else begin
                    sub_y <= sub_y + 1'b1;
                end
            end
        end
    end

    // address one pixel ahead to hide the ROM latency
    always_comb begin
        col_next = (texel_end && cnt_x != SPR_WIDTH - 1) ? cnt_x + 1'b1 : cnt_x;
        pos      = SPR_ADDRW'(cnt_y * SPR_WIDTH) + SPR_ADDRW'(col_next);
        pix      = data;  // already aligned with sx
        drawing  = (state == ENG_DRAW);
    end

endmodule

`default_nettype wire

//--- logic/sprite_pkg.sv
// ==================================================
// sizes are fixed by the texel file sprite_walk.mem
// coordinates are signed; blanking sits at negative sx, sy
// ==================================================
`default_nettype none

package sprite_pkg;
    // raster
    localparam int CORDW = 16;
    localparam logic signed [CORDW-1:0] H_RES  = 16'sd64;
    localparam logic signed [CORDW-1:0] V_RES  = 16'sd40;
    localparam logic signed [CORDW-1:0] H_STA  = -16'sd16;
    localparam logic signed [CORDW-1:0] V_STA  = -16'sd6;
    localparam logic signed [CORDW-1:0] H_END  = H_RES - 16'sd1;  // last column
    localparam logic signed [CORDW-1:0] V_END  = V_RES - 16'sd1;
    localparam logic signed [CORDW-1:0] HS_STA = -16'sd12;
    localparam logic signed [CORDW-1:0] HS_END = -16'sd5;
    localparam logic signed [CORDW-1:0] VS_STA = -16'sd5;
    localparam logic signed [CORDW-1:0] VS_END = -16'sd3;

    // sprite geometry
    localparam int SPR_WIDTH   = 8;
    localparam int SPR_HEIGHT  = 4;
    localparam int SPR_SCALE_X = 2;
    localparam int SPR_SCALE_Y = 2;
    localparam int SPR_FRAMES  = 3;
    localparam int SPR_PIXELS  = SPR_WIDTH * SPR_HEIGHT;
    localparam int SPR_ADDRW   = $clog2(SPR_PIXELS * SPR_FRAMES);
    localparam int COLR_BITS   = 4;
    localparam logic [COLR_BITS-1:0] SPR_TRANS = 4'd9;

    // motion and animation
    localparam logic signed [CORDW-1:0] SPR_Y       = 16'sd16;
    localparam logic signed [CORDW-1:0] SPR_SPEED_X = 16'sd4;   // leftwards
    localparam logic signed [CORDW-1:0] SPR_X_MIN   = -16'sd12;
    localparam int ANIM_STEP = 4;
    localparam int ANIM_LEN  = 4;
    localparam logic [1:0] ANIM_SEQ [ANIM_LEN] = '{2'd0, 2'd1, 2'd0, 2'd2};

    // sprite engine states
    localparam logic [1:0] ENG_IDLE  = 2'd0;
    localparam logic [1:0] ENG_AWAIT = 2'd1;  // wait for position
    localparam logic [1:0] ENG_DRAW  = 2'd2;
    localparam logic [1:0] ENG_NEXT  = 2'd3;  // rest of line after draw

    // RGB444 colours
    localparam logic [11:0] PALETTE [16] = '{
        12'h000, 12'h222, 12'h555, 12'h888, 12'hBBB, 12'hFFF, 12'h630, 12'hA62,
        12'hFC8, 12'hF0F, 12'h02A, 12'h15D, 12'h3AF, 12'hD20, 12'hFA0, 12'h2A3
    };
    localparam logic [11:0] BG_BANDS [5] = '{
        12'h239, 12'h24A, 12'h25B, 12'h26C, 12'h27D  // one per 8 lines
    };
endpackage

`default_nettype wire

//--- logic/sprite_rom.sv
// ==================================================
// one cycle read latency; contents come from sprite_walk.mem
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module sprite_rom import sprite_pkg::*; (
    input  logic                 clk_pix,
    input  logic [SPR_ADDRW-1:0] base,
    input  logic [SPR_ADDRW-1:0] pos,
    output logic [COLR_BITS-1:0] data
);

    localparam SPR_FILE = "sprite_walk.mem";

    logic [COLR_BITS-1:0] rom [SPR_FRAMES*SPR_PIXELS];
    logic [SPR_ADDRW-1:0] addr;

    initial begin
        $readmemh(SPR_FILE, rom);
    end

    assign addr = base + pos;  // frame base plus texel offset

    always_ff @(posedge clk_pix) begin
        data <= rom[addr];
    end

endmodule

`default_nettype wire

//--- logic/sprite_walk_top.sv
// ==================================================
// parallel RGB444 out, one cycle after the scan counters
// no clock generation or TMDS; rst is synchronous
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module sprite_walk_top import sprite_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue,
    output logic       hsync,
    output logic       vsync,
    output logic       de
);

    logic signed [CORDW-1:0] sx;
    logic signed [CORDW-1:0] sy;
    logic signed [CORDW-1:0] sprx;
    logic tg_hsync;  // raw timing, before the output register
    logic tg_vsync;
    logic tg_de;
    logic frame;
    logic line;
    logic spr_start;
    logic spr_drawing;
    logic [SPR_ADDRW-1:0] spr_base;
    logic [SPR_ADDRW-1:0] spr_pos;
    logic [COLR_BITS-1:0] rom_data;
    logic [COLR_BITS-1:0] spr_pix;

    display_timings timings_inst (
        .clk_pix,
        .rst,
        .sx,
        .sy,
        .hsync (tg_hsync),
        .vsync (tg_vsync),
        .de    (tg_de),
        .frame,
        .line
    );

    sprite_animator animator_inst (
        .clk_pix,
        .rst,
        .frame,
        .line,
        .sy,
        .sprx,
        .spr_base,
        .start (spr_start)
    );

    sprite_rom rom_inst (
        .clk_pix,
        .base (spr_base),
        .pos  (spr_pos),
        .data (rom_data)
    );

    sprite_engine engine_inst (
        .clk_pix,
        .rst,
        .start   (spr_start),
        .sx,
        .sprx,
        .data    (rom_data),
        .pos     (spr_pos),
        .pix     (spr_pix),
        .drawing (spr_drawing)
    );

    pixel_compositor compositor_inst (
        .clk_pix,
        .rst,
        .hsync   (tg_hsync),
        .vsync   (tg_vsync),
        .de      (tg_de),
        .drawing (spr_drawing),
        .sy,
        .pix     (spr_pix),
        .red,
        .green,
        .blue,
        .hsync_o (hsync),
        .vsync_o (vsync),
        .de_o    (de)
    );

endmodule

`default_nettype wire

//--- sprite_walk.f
logic/sprite_pkg.sv
logic/display_timings.sv
logic/sprite_animator.sv
logic/sprite_rom.sv
logic/sprite_engine.sv
logic/pixel_compositor.sv
logic/sprite_walk_top.sv
verification/sprite_walk_asserts.sv
verification/sprite_walk_tb.sv

//--- sprite_walk.mem
// three sprite frames of 4 lines each, 8 hex palette indices per line
// index 9 is transparent; frame order in the file: stand, left step, right step
9 9 5 5 5 5 9 9
9 5 0 5 5 0 5 9
9 9 7 7 7 7 9 9
9 9 6 9 9 6 9 9
9 9 5 5 5 5 9 9
9 5 0 5 5 0 5 9
9 7 7 7 7 D 9 9
9 6 9 9 9 9 6 9
9 9 5 5 5 5 9 9
9 5 0 5 5 0 5 9
9 9 D 7 7 7 7 9
9 9 9 6 6 9 9 9

//--- verification/sprite_walk_asserts.sv
// ==================================================
// bound into sprite_walk_top; checks output sync and reset
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module sprite_walk_asserts import sprite_pkg::*; (
    input logic                    clk_pix,
    input logic                    rst,
    input logic                    hsync,
    input logic                    vsync,
    input logic                    de,
    input logic                    spr_drawing,
    input logic signed [CORDW-1:0] sx
);

    // sync pulses live in blanking only
    sync_outside_active: assert property (@(posedge clk_pix) disable iff (rst)
        !(de && (hsync || vsync)))
        else $error("sync high while data enable is high");

    // visible sprite pixels must land in the active area
    drawing_reaches_output: assert property (@(posedge clk_pix) disable iff (rst)
        (spr_drawing && sx >= 16'sd0) |=> de)
        else $error("sprite drawn on screen but de low at the outputs");

    quiet_after_reset: assert property (@(posedge clk_pix)
        rst |=> (!de && !hsync && !vsync))
        else $error("outputs active in the cycle after reset");

endmodule

`default_nettype wire

//--- verification/sprite_walk_tb.sv
// ==================================================
// reads sprite_walk.mem from the project root
// outputs are compared at the falling edge, one cycle behind the model
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module sprite_walk_tb import sprite_pkg::*; ();

    localparam TEXEL_FILE = "sprite_walk.mem";
    localparam int LINE_CYCLES    = int'(H_RES) - int'(H_STA);
    localparam int FRAME_CYCLES   = LINE_CYCLES * (int'(V_RES) - int'(V_STA));
    localparam int ACTIVE_CYCLES  = int'(H_RES) * int'(V_RES);
    localparam int TIMEOUT_CYCLES = 48 * FRAME_CYCLES;
    localparam int K_BLANK  = 0;
    localparam int K_BG     = 1;
    localparam int K_OPAQUE = 2;
    localparam int K_TRANS  = 3;
    localparam int K_CLIP   = 4;  // inside the sprite but left of sx 0

    logic       clk_pix;
    logic       rst;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;
    logic       vsync;
    logic       de;

    integer seed = 32'hae78_88bc;
    logic [COLR_BITS-1:0] texels [SPR_FRAMES*SPR_PIXELS];

    // model state mirroring the scan position
    int m_sx;
    int m_sy;
    int m_sprx;
    int m_step;
    int m_seq;

    // expectation for the outputs after the next edge
    int          exp_sx;
    int          exp_sy;
    int          exp_kind;
    logic [11:0] exp_rgb;
    logic        exp_hs;
    logic        exp_vs;
    logic        exp_de;
    logic        exp_first;
    logic        exp_reset = 1'b0;
    logic        exp_valid = 1'b0;

    int   checks [1:6];
    int   errors [1:6];
    int   frame_cycles;
    int   frame_des;
    int   frames_since_reset;
    int   cycle_count;
    logic in_frame = 1'b0;
    logic vs_prev = 1'b0;
    logic in_restart = 1'b0;  // first frames after the mid-run reset
    logic mid_reset_seen = 1'b0;

    sprite_walk_top DUT (
        .clk_pix (clk_pix),
        .rst     (rst),
        .red     (red),
        .green   (green),
        .blue    (blue),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de)
    );

    bind sprite_walk_top sprite_walk_asserts asserts_inst (
        .clk_pix     (clk_pix),
        .rst         (rst),
        .hsync       (hsync),
        .vsync       (vsync),
        .de          (de),
        .spr_drawing (spr_drawing),
        .sx          (sx)
    );

    always #50 clk_pix = ~clk_pix;

    // walk cycle of stand, left step, stand, right step
    function automatic int anim_frame(input int seq_idx);
        case (seq_idx)
            1:       return 1;
            3:       return 2;
            default: return 0;
        endcase
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "raster timing";
            2:       return "background";
            3:       return "sprite pixels";
            4:       return "transparency";
            5:       return "motion and animation";
            default: return "random reset";
        endcase
    endfunction

    task automatic count_result(input int test, input logic ok);
        checks[test] = checks[test] + 1;
        if (!ok) begin
            errors[test] = errors[test] + 1;
        end
    endtask

    task automatic check_value(input int test, input int also, input string name,
                               input logic [31:0] got, input logic [31:0] want);
        logic ok;
        ok = (got === want);
        assert (ok) else begin
            $display("MISMATCH %s: got %h, expected %h at sx %0d sy %0d",
                     name, got, want, exp_sx, exp_sy);
        end
        count_result(test, ok);
        if (also != 0) begin
            count_result(also, ok);
        end
        if (in_restart && test != 6) begin
            count_result(6, ok);
        end
    endtask

    task automatic wait_frames(input int count);
        repeat (count) @(posedge vsync);
    endtask

    always @(posedge clk_pix) begin : ref_model
        int          row;
        int          col;
        int          kind;
        logic        active;
        logic        in_rect;
        logic [11:0] rgb;
        logic [COLR_BITS-1:0] texel;
        if (rst) begin
            m_sx      <= int'(H_STA);
            m_sy      <= int'(V_STA);
            m_sprx    <= 0;
            m_step    <= 0;
            m_seq     <= 0;
            exp_reset <= 1'b1;
            exp_valid <= 1'b0;
        end else begin
            active  = (m_sx >= 0) && (m_sy >= 0);
            in_rect = (m_sy >= SPR_Y) && (m_sy < SPR_Y + SPR_HEIGHT * SPR_SCALE_Y)
                   && (m_sx >= m_sprx) && (m_sx < m_sprx + SPR_WIDTH * SPR_SCALE_X);
            texel = '0;
            if (in_rect) begin
                row   = (m_sy - SPR_Y) / SPR_SCALE_Y;
                col   = (m_sx - m_sprx) / SPR_SCALE_X;
                texel = texels[anim_frame(m_seq) * SPR_PIXELS + row * SPR_WIDTH + col];
            end
            if (!active) begin
                rgb  = 12'h000;
                kind = in_rect ? K_CLIP : K_BLANK;
            end else if (in_rect && texel != SPR_TRANS) begin
                rgb  = PALETTE[texel];
                kind = K_OPAQUE;
            end else begin
                rgb  = BG_BANDS[m_sy / 8];  // 8-line bands
                kind = in_rect ? K_TRANS : K_BG;
            end

            exp_reset <= 1'b0;
            exp_valid <= 1'b1;
            exp_sx    <= m_sx;
            exp_sy    <= m_sy;
            exp_kind  <= kind;
            exp_rgb   <= rgb;
            exp_hs    <= (m_sx >= HS_STA) && (m_sx <= HS_END);
            exp_vs    <= (m_sy >= VS_STA) && (m_sy <= VS_END);
            exp_de    <= active;
            exp_first <= (m_sx == H_STA) && (m_sy == V_STA);

            if (m_sx == H_RES - 1) begin
                m_sx <= int'(H_STA);
                m_sy <= (m_sy == V_RES - 1) ? int'(V_STA) : m_sy + 1;
            end else begin
                m_sx <= m_sx + 1;
            end

            // once per frame walk left and wrap back to the right edge
            if (m_sx == H_STA && m_sy == V_STA) begin
                m_sprx <= (m_sprx > SPR_X_MIN) ? m_sprx - SPR_SPEED_X : int'(H_RES);
                if (m_step == ANIM_STEP - 1) begin
                    m_step <= 0;
                    m_seq  <= (m_seq + 1) % 4;
                end else begin
                    m_step <= m_step + 1;
                end
            end
        end
    end

    always @(negedge clk_pix) begin : compare
        if (exp_reset) begin
            in_frame           = 1'b0;
            in_restart         = 1'b0;
            frames_since_reset = 0;
            vs_prev            = vsync;
            check_value(6, 0, "rgb", {red, green, blue}, 32'h0);
            check_value(6, 0, "de", de, 32'h0);
            check_value(6, 0, "hsync", hsync, 32'h0);
            check_value(6, 0, "vsync", vsync, 32'h0);
        end else if (exp_valid) begin
            if (exp_first) begin
                frames_since_reset = frames_since_reset + 1;
                in_restart         = mid_reset_seen && (frames_since_reset <= 2);
            end
            // DUT frame length measured from one vsync rise to the next
            if (vsync === 1'b1 && vs_prev !== 1'b1) begin
                if (in_frame) begin
                    check_value(1, 0, "frame_cycles", frame_cycles, FRAME_CYCLES);
                    check_value(1, 0, "de_count", frame_des, ACTIVE_CYCLES);
                end
                in_frame     = 1'b1;
                frame_cycles = 0;
                frame_des    = 0;
            end
            vs_prev      = vsync;
            frame_cycles = frame_cycles + 1;
            if (de === 1'b1) begin
                frame_des = frame_des + 1;
            end
            check_value(1, 0, "hsync", hsync, exp_hs);
            check_value(1, 0, "vsync", vsync, exp_vs);
            check_value(1, 0, "de", de, exp_de);
            case (exp_kind)
                K_BG:     check_value(2, 0, "rgb", {red, green, blue}, exp_rgb);
                K_OPAQUE: check_value(3, 5, "rgb", {red, green, blue}, exp_rgb);
                K_TRANS:  check_value(4, 5, "rgb", {red, green, blue}, exp_rgb);
                K_CLIP:   check_value(5, 0, "rgb", {red, green, blue}, exp_rgb);
                default:  check_value(1, 0, "rgb", {red, green, blue}, exp_rgb);
            endcase
        end
    end

    always @(posedge clk_pix) begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        int frames_before;
        int rst_cycles;
        int offset;
        int total_checks;
        int total_errors;
        int empty;
        clk_pix = 1'b0;
        rst     = 1'b1;
        $readmemh(TEXEL_FILE, texels);
        frames_before = 5 + int'($unsigned($random(seed)) % 16);
        rst_cycles    = 1 + int'($unsigned($random(seed)) % 8);
        offset        = int'($unsigned($random(seed)) % FRAME_CYCLES);  // anywhere in a frame

        repeat (5) @(posedge clk_pix);
        #1 rst = 1'b0;
        wait_frames(frames_before);
        repeat (offset) @(posedge clk_pix);
        #1 rst = 1'b1;
        mid_reset_seen = 1'b1;
        $display("mid-run reset: %0d cycles, %0d frames plus %0d cycles in",
                 rst_cycles, frames_before, offset);
        repeat (rst_cycles) @(posedge clk_pix);
        #1 rst = 1'b0;
        wait_frames(20);
        @(posedge clk_pix);

        total_checks = 0;
        total_errors = 0;
        empty        = 0;
        for (int t = 1; t <= 6; t++) begin
            $display("test %0d %s: %0d checks, %0d errors",
                     t, test_name(t), checks[t], errors[t]);
            total_checks = total_checks + checks[t];
            total_errors = total_errors + errors[t];
            if (checks[t] == 0) begin
                $display("test %0d ran no checks", t);
                empty = empty + 1;
            end
        end
        $display("summary: %0d checks, %0d errors, %0d empty tests",
                 total_checks, total_errors, empty);
        if (total_errors == 0 && empty == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
